//--- verilog.f
dcache_pkg.sv
dcache_req_buf.sv
dcache_way.sv
dcache_lru.sv
dcache_resp_sel.sv
dcache_ctrl.sv
dcache_top.sv
dcache_assert.sv
dcache_tb.sv

//--- dcache_tb.sv
//////////////////////////////////////////////////////////////////////
// directed testbench for the data cache with a random-latency memory
// model, a shadow memory for expected data and a watchdog
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dcache_tb
    import dcache_pkg::*;
();

    localparam int OFFSET_W        = 2;
    localparam int LINE_W          = 32 << OFFSET_W;
    localparam int CLK_PERIOD      = 10;
    localparam int RESET_CYCLES    = 16;
    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 200;
    localparam int MARGIN_CYCLES   = 100;

    logic              clk;
    logic              rstn;
    logic              req_valid;
    logic              req_ready;
    logic              req_wr;
    logic              req_op;
    word_t             req_addr;
    word_t             req_wdata;
    strb_t             req_wstrb;
    logic              resp_valid;
    word_t             resp_rdata;
    logic              mem_req;
    logic              mem_wr;
    word_t             mem_addr;
    word_t             mem_wdata;
    strb_t             mem_wstrb;
    logic              mem_addr_ok;
    logic              mem_data_ok;
    logic [LINE_W-1:0] mem_rdata;

    integer seed = 32'h82ac01b5;
    word_t  mem_words [word_t];
    word_t  shadow [word_t];
    int     read_count = 0;
    int     write_count = 0;
    int     resp_count = 0;
    word_t  last_rd_addr;
    word_t  last_wr_addr;
    word_t  last_wr_data;
    strb_t  last_wr_strb;
    word_t  last_rdata;

    dcache_top i_dcache_top (
        .clk         (clk),
        .rstn        (rstn),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req_wr      (req_wr),
        .req_op      (req_op),
        .req_addr    (req_addr),
        .req_wdata   (req_wdata),
        .req_wstrb   (req_wstrb),
        .resp_valid  (resp_valid),
        .resp_rdata  (resp_rdata),
        .mem_req     (mem_req),
        .mem_wr      (mem_wr),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_rdata   (mem_rdata)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD/2) clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // memory contents and expected data
    //////////////////////////////////////////////////////////////////////
    function automatic word_t word_align(input word_t addr);
        return {addr[31:2], 2'b00};
    endfunction

    function automatic word_t line_base(input word_t addr);
        return addr & ~word_t'((4 << OFFSET_W) - 1);
    endfunction

    // initial memory word, halves swapped and scrambled
    function automatic word_t fill_word(input word_t addr);
        return {addr[15:0], addr[31:16]} ^ 32'h5ac3_96e1;
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t data, input strb_t strb);
        word_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return res;
    endfunction

    function automatic word_t mem_word(input word_t addr);
        if (mem_words.exists(word_align(addr))) begin
            return mem_words[word_align(addr)];
        end
        return fill_word(word_align(addr));
    endfunction

    function automatic word_t shadow_word(input word_t addr);
        if (shadow.exists(word_align(addr))) begin
            return shadow[word_align(addr)];
        end
        return fill_word(word_align(addr));
    endfunction

    //////////////////////////////////////////////////////////////////////
    // memory model, 0 to 3 extra cycles before addr_ok and data_ok
    //////////////////////////////////////////////////////////////////////
    initial begin : memory_model
        int unsigned lat;
        logic        is_read;
        word_t       rd_line;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_rdata   = '0;
        @(posedge rstn);
        @(posedge clk);
        #1;
        forever begin
            if (mem_req) begin
                lat = $unsigned($random(seed)) % 4;
                repeat (lat) begin
                    @(posedge clk);
                    #1;
                end
                mem_addr_ok = 1'b1;
                is_read     = !mem_wr;
                rd_line     = mem_addr;
                if (mem_wr) begin
                    mem_words[word_align(mem_addr)] =
                        merge_bytes(mem_word(mem_addr), mem_wdata, mem_wstrb);
                end
                @(posedge clk);
                #1;
                mem_addr_ok = 1'b0;
                if (is_read) begin
                    lat = $unsigned($random(seed)) % 4;
                    repeat (lat) begin
                        @(posedge clk);
                        #1;
                    end
                    for (int w = 0; w < (1 << OFFSET_W); w++) begin
                        mem_rdata[w*32 +: 32] = mem_word(rd_line + 4*w);
                    end
                    mem_data_ok = 1'b1;
                    @(posedge clk);
                    #1;
                    mem_data_ok = 1'b0;
                end
            end else begin
                @(posedge clk);
                #1;
            end
        end
    end

    // bus and response monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (rstn) begin
            if (mem_req && mem_addr_ok) begin
                if (mem_wr) begin
                    write_count++;
                    last_wr_addr = mem_addr;
                    last_wr_data = mem_wdata;
                    last_wr_strb = mem_wstrb;
                end else begin
                    read_count++;
                    last_rd_addr = mem_addr;
                end
            end
            if (resp_valid) begin
                resp_count++;
                last_rdata = resp_rdata;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // error handling and compare tasks
    //////////////////////////////////////////////////////////////////////
    task automatic stop_with_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_word(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_strb(input string name, input strb_t actual, input strb_t expected);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
            stop_with_failure();
        end
    endtask

    always @(negedge clk) begin
        if (i_dcache_top.i_assert.fail_count != 0) begin
            $display("A protocol assertion on the cache ports failed at %0t ns", $time);
            stop_with_failure();
        end
    end

    initial begin : watchdog
        repeat (RESET_CYCLES + NUM_TESTS*CYCLES_PER_TEST + MARGIN_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not finish in the allowed number of cycles");
        stop_with_failure();
    end

    //////////////////////////////////////////////////////////////////////
    // request driver and per-request checks
    //////////////////////////////////////////////////////////////////////
    task automatic send_request(input logic wr, input logic op, input word_t addr,
                                input word_t wdata, input strb_t wstrb);
        logic taken;
        req_valid = 1'b1;
        req_wr    = wr;
        req_op    = op;
        req_addr  = addr;
        req_wdata = wdata;
        req_wstrb = wstrb;
        taken     = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = req_ready;
            @(posedge clk);
            #1;
        end
        req_valid = 1'b0;
        req_wr    = 1'b0;
        req_op    = 1'b0;
    endtask

    task automatic load_and_check(input word_t addr, input int exp_reads);
        int reads_before;
        int resps_before;
        int cycles;
        reads_before = read_count;
        resps_before = resp_count;
        cycles       = 0;
        send_request(1'b0, 1'b0, addr, '0, '0);
        while (resp_count == resps_before) begin
            @(posedge clk);
            cycles++;
        end
        #1;
        check_word("resp_rdata", last_rdata, shadow_word(addr));
        check_word("memory read count", word_t'(read_count - reads_before), word_t'(exp_reads));
        if (exp_reads > 0) begin
            check_word("read mem_addr", last_rd_addr, line_base(addr));
        end else begin
            // accept edge to response is two cycles on a hit
            check_word("load hit latency", word_t'(cycles), 32'd2);
        end
    endtask

    task automatic store_and_check(input word_t addr, input word_t data, input strb_t strb);
        int writes_before;
        int reads_before;
        writes_before = write_count;
        reads_before  = read_count;
        send_request(1'b1, 1'b0, addr, data, strb);
        while (write_count == writes_before) @(posedge clk);
        #1;
        check_word("write mem_addr", last_wr_addr, addr);
        check_word("write mem_wdata", last_wr_data, data);
        check_strb("write mem_wstrb", last_wr_strb, strb);
        check_word("memory read count", word_t'(read_count - reads_before), 32'd0);
        shadow[word_align(addr)] = merge_bytes(shadow_word(addr), data, strb);
    endtask

    //////////////////////////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////////////////////////
    task automatic test_reset();
        $display("test: reset state");
        check_bit("req_ready", req_ready, 1'b1);
        check_bit("mem_req", mem_req, 1'b0);
        check_bit("resp_valid", resp_valid, 1'b0);
    endtask

    task automatic test_load_miss_hit();
        $display("test: load miss then hit");
        load_and_check(32'h0000_1024, 1);
        load_and_check(32'h0000_102c, 0);
    endtask

    task automatic test_store_hit();
        $display("test: store hit with write-through");
        store_and_check(32'h0000_1028, 32'hdead_beef, 4'b0110);
        load_and_check(32'h0000_1028, 0);
    endtask

    task automatic test_store_miss();
        $display("test: store miss without allocation");
        store_and_check(32'h0000_2034, 32'h1357_9bdf, 4'b1001);
        load_and_check(32'h0000_2034, 1);
    endtask

    // lines A, B and C all map to set 5
    task automatic test_replacement();
        $display("test: LRU replacement");
        load_and_check(32'h0000_3050, 1);
        load_and_check(32'h0000_4050, 1);
        load_and_check(32'h0000_3050, 0);
        load_and_check(32'h0000_5050, 1);
        load_and_check(32'h0000_3054, 0);
        load_and_check(32'h0000_4058, 1);
    endtask

    task automatic test_invalidate();
        $display("test: set invalidate");
        load_and_check(32'h0000_6060, 1);
        load_and_check(32'h0000_6064, 0);
        send_request(1'b0, 1'b1, 32'h0000_6060, '0, '0);
        load_and_check(32'h0000_6060, 1);
    endtask

    initial begin
        rstn      = 1'b0;
        req_valid = 1'b0;
        req_wr    = 1'b0;
        req_op    = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_wstrb = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rstn = 1'b1;
        test_reset();
        test_load_miss_hit();
        test_store_hit();
        test_store_miss();
        test_replacement();
        test_invalidate();
        if (i_dcache_top.i_assert.fail_count != 0) begin
            $display("A protocol assertion on the cache ports failed during the run");
            stop_with_failure();
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

//--- dcache_assert.sv
//////////////////////////////////////////////////////////////////////
// protocol checks on the memory and response ports of the cache,
// attached to every dcache_top instance with bind
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dcache_assert
    import dcache_pkg::*;
(
    input logic  clk,
    input logic  rstn,
    input logic  req_valid,
    input logic  req_ready,
    input logic  req_wr,
    input logic  req_op,
    input logic  mem_req,
    input logic  mem_wr,
    input word_t mem_addr,
    input word_t mem_wdata,
    input strb_t mem_wstrb,
    input logic  mem_addr_ok,
    input logic  resp_valid
);

    // number of failed assertions
    int   fail_count = 0;

    // loads accepted on the pipeline port and not yet answered
    int   loads_open;
    logic load_taken;

    assign load_taken = req_valid && req_ready && !req_wr && !req_op;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            loads_open <= 0;
        end else if (load_taken && !resp_valid) begin
            loads_open <= loads_open + 1;
        end else if (resp_valid && !load_taken) begin
            loads_open <= loads_open - 1;
        end
    end

    // a request may only end with addr_ok
    property req_held_until_ok;
        @(posedge clk) disable iff (!rstn)
            mem_req && !mem_addr_ok |=> mem_req;
    endproperty

    // companions frozen while memory holds off
    property req_stable_while_waiting;
        @(posedge clk) disable iff (!rstn)
            mem_req && !mem_addr_ok |=> $stable(mem_wr) && $stable(mem_addr)
                && $stable(mem_wdata) && $stable(mem_wstrb);
    endproperty

    // every response cycle answers a load that is still open
    property resp_single_cycle;
        @(posedge clk) disable iff (!rstn)
            resp_valid |-> loads_open > 0;
    endproperty

    a_req_held: assert property (req_held_until_ok) else begin
        fail_count++;
        $error("mem_req dropped before mem_addr_ok");
    end

    a_req_stable: assert property (req_stable_while_waiting) else begin
        fail_count++;
        $error("memory request changed while waiting for mem_addr_ok");
    end

    a_resp_single: assert property (resp_single_cycle) else begin
        fail_count++;
        $error("resp_valid held for two cycles for one load");
    end

endmodule

bind dcache_top dcache_assert i_assert (
    .clk         (clk),
    .rstn        (rstn),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .req_wr      (req_wr),
    .req_op      (req_op),
    .mem_req     (mem_req),
    .mem_wr      (mem_wr),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .mem_wstrb   (mem_wstrb),
    .mem_addr_ok (mem_addr_ok),
    .resp_valid  (resp_valid)
);

//--- dcache_top.sv
//////////////////////////////////////////////////////////////////////
// two-way write-through data cache, pipeline port on one side and a
// line-read, word-write memory port on the other
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dcache_top
    import dcache_pkg::*;
#(
    parameter int INDEX_W  = 4,
    parameter int OFFSET_W = 2
) (
    input  logic                      clk,
    input  logic                      rstn,
    // pipeline side
    input  logic                      req_valid,
    output logic                      req_ready,
    input  logic                      req_wr,
    input  logic                      req_op,
    input  word_t                     req_addr,
    input  word_t                     req_wdata,
    input  strb_t                     req_wstrb,
    output logic                      resp_valid,
    output word_t                     resp_rdata,
    // memory side
    output logic                      mem_req,
    output logic                      mem_wr,
    output word_t                     mem_addr,
    output word_t                     mem_wdata,
    output strb_t                     mem_wstrb,
    input  logic                      mem_addr_ok,
    input  logic                      mem_data_ok,
    input  logic [(32<<OFFSET_W)-1:0] mem_rdata
);

    localparam int LINE_W = 32 << OFFSET_W;

    logic              buf_load;
    word_t             buf_addr;
    word_t             buf_wdata;
    strb_t             buf_wstrb;
    logic              buf_wr;
    logic              buf_op;
    way_mask_t         hit;
    way_mask_t         way_write;
    way_mask_t         way_fill;
    way_mask_t         set_inval;
    logic              touch;
    logic              touch_way;
    logic              victim;
    logic              load_done;
    logic              from_refill;
    logic [LINE_W-1:0] way_lines [NUM_WAYS];

    dcache_req_buf i_req_buf (
        .clk       (clk),
        .rstn      (rstn),
        .load      (buf_load),
        .addr      (req_addr),
        .wdata     (req_wdata),
        .wstrb     (req_wstrb),
        .wr        (req_wr),
        .op        (req_op),
        .buf_addr  (buf_addr),
        .buf_wdata (buf_wdata),
        .buf_wstrb (buf_wstrb),
        .buf_wr    (buf_wr),
        .buf_op    (buf_op)
    );

    dcache_ctrl #(
        .INDEX_W  (INDEX_W),
        .OFFSET_W (OFFSET_W)
    ) i_ctrl (
        .clk         (clk),
        .rstn        (rstn),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .buf_load    (buf_load),
        .buf_wr      (buf_wr),
        .buf_op      (buf_op),
        .buf_addr    (buf_addr),
        .buf_wstrb   (buf_wstrb),
        .buf_wdata   (buf_wdata),
        .hit         (hit),
        .victim      (victim),
        .way_write   (way_write),
        .way_fill    (way_fill),
        .set_inval   (set_inval),
        .touch       (touch),
        .touch_way   (touch_way),
        .load_done   (load_done),
        .from_refill (from_refill),
        .mem_req     (mem_req),
        .mem_wr      (mem_wr),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok)
    );

    dcache_lru #(
        .INDEX_W (INDEX_W)
    ) i_lru (
        .clk       (clk),
        .rstn      (rstn),
        .index     (buf_addr[OFFSET_W+2 +: INDEX_W]),
        .touch     (touch),
        .touch_way (touch_way),
        .victim    (victim)
    );

    // the ways, all fed from the buffered request
    for (genvar g = 0; g < NUM_WAYS; g++) begin : g_way
        dcache_way #(
            .INDEX_W  (INDEX_W),
            .OFFSET_W (OFFSET_W)
        ) i_way (
            .clk       (clk),
            .rstn      (rstn),
            .addr      (buf_addr),
            .wdata     (buf_wdata),
            .wstrb     (buf_wstrb),
            .write     (way_write[g]),
            .fill      (way_fill[g]),
            .fill_line (mem_rdata),
            .inval     (set_inval[g]),
            .hit       (hit[g]),
            .line      (way_lines[g])
        );
    end

    dcache_resp_sel #(
        .OFFSET_W (OFFSET_W)
    ) i_resp_sel (
        .clk         (clk),
        .rstn        (rstn),
        .hit         (hit),
        .way_lines   (way_lines),
        .refill_line (mem_rdata),
        .from_refill (from_refill),
        .load_done   (load_done),
        .offset      (buf_addr[2 +: OFFSET_W]),
        .resp_valid  (resp_valid),
        .resp_rdata  (resp_rdata)
    );

endmodule

//--- dcache_ctrl.sv
//////////////////////////////////////////////////////////////////////
// main cache FSM: lookup, line refill on load miss, store write-through
// and set invalidate, with outputs decoded from current and next state
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dcache_ctrl
    import dcache_pkg::*;
#(
    parameter int INDEX_W  = 4,
    parameter int OFFSET_W = 2
) (
    input  logic      clk,
    input  logic      rstn,
    input  logic      req_valid,
    output logic      req_ready,
    output logic      buf_load,
    input  logic      buf_wr,
    input  logic      buf_op,
    input  word_t     buf_addr,
    input  strb_t     buf_wstrb,
    input  word_t     buf_wdata,
    input  way_mask_t hit,
    input  logic      victim,
    output way_mask_t way_write,
    output way_mask_t way_fill,
    output way_mask_t set_inval,
    output logic      touch,
    output logic      touch_way,
    output logic      load_done,
    output logic      from_refill,
    output logic      mem_req,
    output logic      mem_wr,
    output word_t     mem_addr,
    output word_t     mem_wdata,
    output strb_t     mem_wstrb,
    input  logic      mem_addr_ok,
    input  logic      mem_data_ok
);

    localparam int TAG_W = 32 - INDEX_W - OFFSET_W - 2;

    ctrl_state_t state;
    ctrl_state_t next_state;
    logic        any_hit;
    logic        req_done;
    word_t       line_addr;

    assign any_hit   = |hit;
    assign line_addr = {buf_addr[31 -: TAG_W+INDEX_W], {(OFFSET_W+2){1'b0}}};

    //////////////////////////////////////////////////////////////////////
    // completion of the current request, the cache can take a new one
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (state)
            st_idle, st_cache_op: req_done = 1'b1;
            st_lookup: req_done = !buf_op && !buf_wr && any_hit;
            st_hit_write, st_miss_write: req_done = mem_addr_ok;
            st_miss_read_wait: req_done = mem_data_ok;
            default: req_done = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        if (req_done) begin
            next_state = req_valid ? st_lookup : st_idle;
        end else begin
            case (state)
                st_lookup: begin
                    if (buf_op) begin
                        next_state = st_cache_op;
                    end else if (!any_hit) begin
                        next_state = buf_wr ? st_miss_write : st_miss_read;
                    end else begin
                        next_state = st_hit_write;
                    end
                end
                st_miss_read: begin
                    if (mem_addr_ok) begin
                        next_state = st_miss_read_wait;
                    end
                end
                default: next_state = state;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output decode
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        way_write   = '0;
        way_fill    = '0;
        set_inval   = '0;
        touch       = 1'b0;
        touch_way   = hit[1];
        load_done   = 1'b0;
        from_refill = 1'b0;
        mem_req     = 1'b0;
        mem_wr      = 1'b0;
        case (state)
            st_lookup: begin
                if (next_state == st_hit_write) begin
                    // merge now, the write-through follows
                    way_write = hit;
                    touch     = 1'b1;
                end else if (req_done) begin
                    load_done = 1'b1;
                    touch     = 1'b1;
                end
            end
            st_cache_op: begin
                set_inval = '1;
            end
            st_hit_write, st_miss_write: begin
                mem_req = 1'b1;
                mem_wr  = 1'b1;
            end
            st_miss_read: begin
                mem_req = 1'b1;
            end
            st_miss_read_wait: begin
                if (next_state != st_miss_read_wait) begin
                    // line arrives, fill the victim and answer from the bus
                    way_fill[victim] = 1'b1;
                    touch            = 1'b1;
                    touch_way        = victim;
                    load_done        = 1'b1;
                    from_refill      = 1'b1;
                end
            end
            default: begin
                mem_req = 1'b0;
            end
        endcase
    end

    assign req_ready = req_done;
    assign buf_load  = req_done && req_valid;

    // reads fetch the whole line, writes go out as one word
    assign mem_addr  = mem_wr ? buf_addr : line_addr;
    assign mem_wdata = buf_wdata;
    assign mem_wstrb = mem_wr ? buf_wstrb : 4'b0000;

endmodule

//--- dcache_resp_sel.sv
//////////////////////////////////////////////////////////////////////
// load response path: line select, word extract and output register
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dcache_resp_sel
    import dcache_pkg::*;
#(
    parameter int OFFSET_W = 2
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  way_mask_t                 hit,
    input  logic [(32<<OFFSET_W)-1:0] way_lines [NUM_WAYS],
    input  logic [(32<<OFFSET_W)-1:0] refill_line,
    input  logic                      from_refill,
    input  logic                      load_done,
    input  logic [OFFSET_W-1:0]       offset,
    output logic                      resp_valid,
    output word_t                     resp_rdata
);

    localparam int LINE_W = 32 << OFFSET_W;

    logic [LINE_W-1:0] hit_line;
    logic [LINE_W-1:0] sel_line;
    word_t             sel_word;

    // hit is one-hot, so an or of the gated lines is a mux
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (hit[w]) begin
                hit_line = hit_line | way_lines[w];
            end
        end
    end

    assign sel_line = from_refill ? refill_line : hit_line;
    assign sel_word = sel_line[offset*32 +: 32];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= load_done;
        end
    end

    always_ff @(posedge clk) begin
        if (load_done) begin
            resp_rdata <= sel_word;
        end
    end

endmodule

//--- dcache_lru.sv
//////////////////////////////////////////////////////////////////////
// replacement state, one bit per set naming the least recently used way
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dcache_lru #(
    parameter int INDEX_W = 4
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic [INDEX_W-1:0] index,
    input  logic               touch,
    input  logic               touch_way,
    output logic               victim
);

    logic [(1<<INDEX_W)-1:0] lru_bits;

    assign victim = lru_bits[index];

    // the way not just used becomes the next victim
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lru_bits <= '0;
        end else if (touch) begin
            lru_bits[index] <= ~touch_way;
        end
    end

endmodule

//--- dcache_way.sv
//////////////////////////////////////////////////////////////////////
// one cache way: tag, valid and line storage with a combinational
// hit compare, refill, store merge and set invalidate
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dcache_way
    import dcache_pkg::*;
#(
    parameter int INDEX_W  = 4,
    parameter int OFFSET_W = 2
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  word_t                     addr,
    input  word_t                     wdata,
    input  strb_t                     wstrb,
    input  logic                      write,
    input  logic                      fill,
    input  logic [(32<<OFFSET_W)-1:0] fill_line,
    input  logic                      inval,
    output logic                      hit,
    output logic [(32<<OFFSET_W)-1:0] line
);

    localparam int LINE_W = 32 << OFFSET_W;
    localparam int TAG_W  = 32 - INDEX_W - OFFSET_W - 2;
    localparam int SETS   = 1 << INDEX_W;

    logic [TAG_W-1:0]    tag_mem  [SETS];
    logic [LINE_W-1:0]   data_mem [SETS];
    logic [SETS-1:0]     valid;

    logic [TAG_W-1:0]    addr_tag;
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-1:0] word_off;
    logic [LINE_W-1:0]   merged_line;

    assign addr_tag = addr[31 -: TAG_W];
    assign index    = addr[OFFSET_W+2 +: INDEX_W];
    assign word_off = addr[2 +: OFFSET_W];

    assign line = data_mem[index];
    assign hit  = valid[index] && (tag_mem[index] == addr_tag);

    // store data merged byte by byte into the addressed word
    always_comb begin
        merged_line = line;
        for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) begin
                merged_line[word_off*32 + b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_mem[index]  <= addr_tag;
            data_mem[index] <= fill_line;
        end else if (write) begin
            data_mem[index] <= merged_line;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid <= '0;
        end else if (fill) begin
            valid[index] <= 1'b1;
        end else if (inval) begin
            valid[index] <= 1'b0;
        end
    end

endmodule

//--- dcache_req_buf.sv
//////////////////////////////////////////////////////////////////////
// request buffer, holds the accepted pipeline request until it retires
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dcache_req_buf
    import dcache_pkg::*;
(
    input  logic  clk,
    input  logic  rstn,
    input  logic  load,
    input  word_t addr,
    input  word_t wdata,
    input  strb_t wstrb,
    input  logic  wr,
    input  logic  op,
    output word_t buf_addr,
    output word_t buf_wdata,
    output strb_t buf_wstrb,
    output logic  buf_wr,
    output logic  buf_op
);

    // request kind flags
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            buf_wr <= 1'b0;
            buf_op <= 1'b0;
        end else if (load) begin
            buf_wr <= wr;
            buf_op <= op;
        end
    end

    // address and store payload
    always_ff @(posedge clk) begin
        if (load) begin
            buf_addr  <= addr;
            buf_wdata <= wdata;
            buf_wstrb <= wstrb;
        end
    end

endmodule

//--- dcache_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared types and constants of the two-way write-through data cache
// imported by every cache block that needs them
//////////////////////////////////////////////////////////////////////

package dcache_pkg;

    // data or address word
    typedef logic [31:0] word_t;

    // byte enables of one word
    typedef logic [3:0] strb_t;

    // replacement is one bit per set, so the cache stays two-way
    localparam int NUM_WAYS = 2;

    // one bit per way, used for hit, fill and write enables
    typedef logic [NUM_WAYS-1:0] way_mask_t;

    //////////////////////////////////////////////////////////////////////
    // controller states
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_cache_op,
        st_hit_write,
        st_miss_read,
        st_miss_read_wait,
        st_miss_write
    } ctrl_state_t;

endpackage
